//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       := tb_rhythm_game
FILELIST  := files.f

SOURCES := $(wildcard hw/*.sv verif/*.sv verif/*.svh)
BIN     := obj_dir/V$(TOP)
LOG     := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- files.f
hw/rhythm_pkg.sv
hw/game_timer.sv
hw/arrow_pattern_gen.sv
hw/player_lanes.sv
hw/score_display.sv
hw/rhythm_game_top.sv
+incdir+verif
verif/tb_rhythm_game.sv

//--- hw/arrow_pattern_gen.sv
`timescale 1ns/1ps
`default_nettype none

module arrow_pattern_gen (
    input  logic                CLOCK_50,
    input  logic                reset,
    input  logic                spawn_tick,
    output logic                pattern_valid,
    output rhythm_pkg::pattern_t pattern
);

    import rhythm_pkg::*;

    lfsr_t      lfsr;
    logic       feedback;
    arrow_set_t next_set;

    // Taps 16, 15, 13, 4
    assign feedback = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];
    assign next_set = pattern_of(lfsr[3:0]);   // Lookup on the pre-shift state

    always_ff @(posedge CLOCK_50 or posedge reset) begin
        if (reset) begin
            lfsr          <= LFSR_SEED;
            pattern_valid <= 1'b0;
        end else begin
            pattern_valid <= spawn_tick;
            if (spawn_tick) begin
                lfsr <= {lfsr[14:0], feedback};
            end
        end
    end

    // Both players always race the same arrows
    always_ff @(posedge CLOCK_50) begin
        if (spawn_tick) begin
            pattern.player_a <= next_set;
            pattern.player_b <= next_set;
        end
    end

endmodule

`default_nettype wire

//--- hw/game_timer.sv
`timescale 1ns/1ps
`default_nettype none

module game_timer #(
    parameter int SPAWN_INTERVAL = 25000000,
    parameter int MOVE_INTERVAL  = 1000000
) (
    input  logic CLOCK_50,
    input  logic reset,
    input  logic game_active,
    output logic spawn_tick,
    output logic move_tick
);

    localparam int SPAWN_W = $clog2(SPAWN_INTERVAL + 1);
    localparam int MOVE_W  = $clog2(MOVE_INTERVAL + 1);

    logic [SPAWN_W-1:0] spawn_count;
    logic [MOVE_W-1:0]  move_count;

    always_ff @(posedge CLOCK_50 or posedge reset) begin
        if (reset) begin
            spawn_count <= '0;
            spawn_tick  <= 1'b0;
            move_count  <= '0;
            move_tick   <= 1'b0;
        end else begin
            spawn_tick <= 1'b0;
            // Spawn count is frozen outside of play
            if (game_active) begin
                if (spawn_count == SPAWN_W'(SPAWN_INTERVAL - 1)) begin
                    spawn_count <= '0;
                    spawn_tick  <= 1'b1;
                end else begin
                    spawn_count <= spawn_count + 1'b1;
                end
            end

            if (move_count == MOVE_W'(MOVE_INTERVAL - 1)) begin
                move_count <= '0;
                move_tick  <= 1'b1;
            end else begin
                move_count <= move_count + 1'b1;
                move_tick  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/player_lanes.sv
`timescale 1ns/1ps
`default_nettype none

module player_lanes (
    input  logic                  CLOCK_50,
    input  logic                  reset,
    input  logic                  pattern_valid,
    input  rhythm_pkg::arrow_set_t arrows,
    input  logic                  move_tick,
    input  rhythm_pkg::arrow_set_t keys,
    output logic                  hit,
    output rhythm_pkg::arrow_set_t lane_active
);

    import rhythm_pkg::*;

    localparam row_t WINDOW_LO = row_t'(TARGET_ROW - HIT_RANGE);
    localparam row_t WINDOW_HI = row_t'(TARGET_ROW + HIT_RANGE);

    row_t       row [4];
    arrow_set_t prev_keys;
    arrow_set_t key_rise;
    arrow_set_t in_window;
    arrow_set_t lane_hit;
    arrow_set_t lane_spawn;
    arrow_set_t lane_move;         // Active lane still on screen at a tick
    arrow_set_t lane_exit;         // Active lane past the bottom at a tick

    assign key_rise = keys & ~prev_keys;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            in_window[i] = (row[i] >= WINDOW_LO) && (row[i] <= WINDOW_HI);
        end
    end

    assign lane_hit   = key_rise & lane_active & in_window;
    assign lane_spawn = {4{pattern_valid}} & arrows & ~lane_active;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            lane_move[i] = lane_active[i] && move_tick && !lane_hit[i]
                           && (row[i] < SCREEN_HEIGHT);
            lane_exit[i] = lane_active[i] && move_tick && !lane_hit[i]
                           && (row[i] >= SCREEN_HEIGHT);
        end
    end

    always_ff @(posedge CLOCK_50 or posedge reset) begin
        if (reset) begin
            lane_active <= '0;
            prev_keys   <= '0;
            hit         <= 1'b0;
        end else begin
            prev_keys <= keys;
            hit       <= |lane_hit;      // One pulse even if two lanes hit together
            // Spawn only touches idle lanes, retire only active ones
            lane_active <= (lane_active & ~lane_hit & ~lane_exit) | lane_spawn;
        end
    end

    // Arrow heights
    always_ff @(posedge CLOCK_50) begin
        for (int i = 0; i < 4; i++) begin
            if (lane_spawn[i]) begin
                row[i] <= '0;
            end else if (lane_move[i]) begin
                row[i] <= row[i] + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/rhythm_game_top.sv
`timescale 1ns/1ps
`default_nettype none

module rhythm_game_top #(
    parameter int SPAWN_INTERVAL = 25000000,
    parameter int MOVE_INTERVAL  = 1000000
) (
    input  logic                  CLOCK_50,
    input  logic                  reset,
    input  logic                  game_active,
    input  rhythm_pkg::arrow_set_t player_a_keys,
    input  rhythm_pkg::arrow_set_t player_b_keys,
    output rhythm_pkg::arrow_set_t lane_active_a,
    output rhythm_pkg::arrow_set_t lane_active_b,
    output logic                  hit_a,
    output logic                  hit_b,
    output rhythm_pkg::seg7_t      hex0,
    output rhythm_pkg::seg7_t      hex1,
    output rhythm_pkg::seg7_t      hex2,
    output rhythm_pkg::seg7_t      hex3
);

    import rhythm_pkg::*;

    logic     spawn_tick;
    logic     move_tick;
    logic     pattern_valid;
    pattern_t pattern;

    game_timer #(
        .SPAWN_INTERVAL(SPAWN_INTERVAL),
        .MOVE_INTERVAL (MOVE_INTERVAL)
    ) i_timer (
        .CLOCK_50   (CLOCK_50),
        .reset      (reset),
        .game_active(game_active),
        .spawn_tick (spawn_tick),
        .move_tick  (move_tick)
    );

    arrow_pattern_gen i_pattern_gen (
        .CLOCK_50     (CLOCK_50),
        .reset        (reset),
        .spawn_tick   (spawn_tick),
        .pattern_valid(pattern_valid),
        .pattern      (pattern)
    );

    // Player A
    player_lanes i_lanes_a (
        .CLOCK_50     (CLOCK_50),
        .reset        (reset),
        .pattern_valid(pattern_valid),
        .arrows       (pattern.player_a),
        .move_tick    (move_tick),
        .keys         (player_a_keys),
        .hit          (hit_a),
        .lane_active  (lane_active_a)
    );

    score_display i_score_a (
        .CLOCK_50(CLOCK_50),
        .reset   (reset),
        .hit     (hit_a),
        .ones    (hex0),
        .tens    (hex1)
    );

    // Player B
    player_lanes i_lanes_b (
        .CLOCK_50     (CLOCK_50),
        .reset        (reset),
        .pattern_valid(pattern_valid),
        .arrows       (pattern.player_b),
        .move_tick    (move_tick),
        .keys         (player_b_keys),
        .hit          (hit_b),
        .lane_active  (lane_active_b)
    );

    score_display i_score_b (
        .CLOCK_50(CLOCK_50),
        .reset   (reset),
        .hit     (hit_b),
        .ones    (hex2),
        .tens    (hex3)
    );

endmodule

`default_nettype wire

//--- hw/rhythm_pkg.sv
`default_nettype none

package rhythm_pkg;

    typedef logic [15:0] lfsr_t;
    typedef logic [3:0]  arrow_set_t;     // Bit 0 left, 1 up, 2 right, 3 down
    typedef logic [6:0]  row_t;
    typedef logic [3:0]  digit_t;
    typedef logic [6:0]  seg7_t;          // Active low

    typedef struct packed {
        arrow_set_t player_a;
        arrow_set_t player_b;
    } pattern_t;

    localparam lfsr_t LFSR_SEED = 16'hACE1;

    localparam arrow_set_t ARROW_LEFT  = 4'b0001;
    localparam arrow_set_t ARROW_UP    = 4'b0010;
    localparam arrow_set_t ARROW_RIGHT = 4'b0100;
    localparam arrow_set_t ARROW_DOWN  = 4'b1000;

    // Playfield geometry in rows
    localparam row_t SCREEN_HEIGHT = 7'd120;
    localparam row_t TARGET_ROW    = 7'd90;
    localparam row_t HIT_RANGE     = 7'd10;

    localparam int SCORE_MAX = 99;

    // Singles for 0..3, pairs for the rest
    function automatic arrow_set_t pattern_of(input logic [3:0] sel);
        case (sel)
            4'd0:         return ARROW_UP;
            4'd1:         return ARROW_DOWN;
            4'd2:         return ARROW_LEFT;
            4'd3:         return ARROW_RIGHT;
            4'd4, 4'd5:   return ARROW_UP | ARROW_DOWN;
            4'd6, 4'd7:   return ARROW_UP | ARROW_LEFT;
            4'd8, 4'd9:   return ARROW_UP | ARROW_RIGHT;
            4'd10, 4'd11: return ARROW_DOWN | ARROW_LEFT;
            4'd12, 4'd13: return ARROW_DOWN | ARROW_RIGHT;
            default:      return ARROW_LEFT | ARROW_RIGHT;
        endcase
    endfunction

    function automatic seg7_t seg7_of(input digit_t d);
        case (d)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0010000;
            default: return 7'b1111111;   // Blank
        endcase
    endfunction

endpackage

`default_nettype wire

//--- hw/score_display.sv
`timescale 1ns/1ps
`default_nettype none

module score_display (
    input  logic             CLOCK_50,
    input  logic             reset,
    input  logic             hit,
    output rhythm_pkg::seg7_t ones,
    output rhythm_pkg::seg7_t tens
);

    import rhythm_pkg::*;

    localparam digit_t MAX_TENS  = digit_t'(SCORE_MAX / 10);
    localparam digit_t MAX_ONES  = digit_t'(SCORE_MAX % 10);
    localparam digit_t LAST_DIGIT = 4'd9;

    digit_t ones_digit;
    digit_t tens_digit;
    logic   at_max;

    assign at_max = (tens_digit == MAX_TENS) && (ones_digit == MAX_ONES);

    // BCD counter that sticks at the top score
    always_ff @(posedge CLOCK_50 or posedge reset) begin
        if (reset) begin
            ones_digit <= '0;
            tens_digit <= '0;
        end else if (hit && !at_max) begin
            if (ones_digit == LAST_DIGIT) begin
                ones_digit <= '0;
                tens_digit <= tens_digit + 1'b1;   // Carry
            end else begin
                ones_digit <= ones_digit + 1'b1;
            end
        end
    end

    assign ones = seg7_of(ones_digit);
    assign tens = seg7_of(tens_digit);

endmodule

`default_nettype wire

//--- verif/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check_set(input string name, input arrow_set_t got, input arrow_set_t exp);
    if (got !== exp) begin
        fail_run($sformatf("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp));
    end
endtask

task automatic check_seg(input string name, input seg7_t got, input seg7_t exp);
    if (got !== exp) begin
        fail_run($sformatf("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp));
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        fail_run($sformatf("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp));
    end
endtask

// Shift left with feedback from bits 15, 14, 12 and 3
function automatic lfsr_t lfsr_next(input lfsr_t s);
    return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
endfunction

// Bit 0 left, 1 up, 2 right, 3 down
function automatic arrow_set_t expected_arrows(input logic [3:0] sel);
    arrow_set_t singles [4];
    arrow_set_t pairs [6];
    singles = '{4'b0010, 4'b1000, 4'b0001, 4'b0100};
    pairs   = '{4'b1010, 4'b0011, 4'b0110, 4'b1001, 4'b1100, 4'b0101};
    if (sel < 4'd4) begin
        return singles[sel[1:0]];
    end
    return pairs[3'((sel - 4'd4) >> 1)];
endfunction

function automatic seg7_t seg_for_digit(input digit_t d);
    seg7_t seg_table [10];
    seg_table = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78, 7'h00, 7'h10};
    return seg_table[d];
endfunction

// Random pick among the set bits
function automatic logic [1:0] pick_lane(input arrow_set_t set);
    int         k;
    arrow_set_t rem;
    logic [1:0] pick;
    k    = int'(lcg_next() % $countones(set));
    rem  = set;
    pick = 2'd0;
    for (int i = 0; i < 4; i++) begin
        if (rem[0]) begin
            if (k == 0) pick = 2'(i);
            k--;
        end
        rem = rem >> 1;
    end
    return pick;
endfunction

task automatic check_scores();
    check_seg("hex0", hex0, seg_for_digit(digit_t'(score_a % 10)));
    check_seg("hex1", hex1, seg_for_digit(digit_t'(score_a / 10)));
    check_seg("hex2", hex2, seg_for_digit(digit_t'(score_b % 10)));
    check_seg("hex3", hex3, seg_for_digit(digit_t'(score_b / 10)));
endtask

task automatic apply_reset();
    @(posedge CLOCK_50);
    reset <= 1'b1;
    repeat (5) @(posedge CLOCK_50);
    reset <= 1'b0;
endtask

task automatic release_keys();
    @(posedge CLOCK_50);
    player_a_keys <= '0;
    player_b_keys <= '0;
endtask

// Ends on the edge after the new arrow shows up with the game paused again
task automatic spawn_arrow(output logic [1:0] lane);
    arrow_set_t old_a;
    arrow_set_t rise;
    int         waited;
    @(negedge CLOCK_50);
    old_a = lane_active_a;
    @(posedge CLOCK_50);
    game_active <= 1'b1;
    rise   = '0;
    waited = 0;
    while (rise == '0) begin
        @(negedge CLOCK_50);
        rise  = lane_active_a & ~old_a;
        old_a = lane_active_a;
        waited++;
        if (waited > 200) begin
            fail_run("No arrow appeared while the game was active");
        end
    end
    lane = pick_lane(rise);
    @(posedge CLOCK_50);
    game_active <= 1'b0;
endtask

// Row rises by one every 2 cycles from activation
task automatic wait_for_row(input int row);
    repeat (2 * row - 2) @(posedge CLOCK_50);
endtask

task automatic hit_lane(input logic on_b, input logic [1:0] lane, input logic expect_hit);
    @(posedge CLOCK_50);
    if (on_b) player_b_keys[lane] <= 1'b1;
    else      player_a_keys[lane] <= 1'b1;
    @(negedge CLOCK_50);
    @(negedge CLOCK_50);                  // One cycle after the key is sampled
    check_bit("hit_a", hit_a, expect_hit && !on_b);
    check_bit("hit_b", hit_b, expect_hit && on_b);
    check_bit(on_b ? "lane_active_b" : "lane_active_a",
              on_b ? lane_active_b[lane] : lane_active_a[lane], !expect_hit);
    if (expect_hit && !on_b && score_a < SCORE_LIMIT) score_a++;
    if (expect_hit && on_b && score_b < SCORE_LIMIT) score_b++;
    @(negedge CLOCK_50);
    check_bit("hit_a", hit_a, 1'b0);      // Single pulse
    check_bit("hit_b", hit_b, 1'b0);
    check_scores();
endtask

task automatic test_reset_state();
    @(negedge CLOCK_50);
    check_set("lane_active_a", lane_active_a, 4'b0000);
    check_set("lane_active_b", lane_active_b, 4'b0000);
    check_bit("hit_a", hit_a, 1'b0);
    check_bit("hit_b", hit_b, 1'b0);
    check_scores();
endtask

task automatic test_pattern_sequence();
    lfsr_t      model;
    arrow_set_t old_a;
    arrow_set_t old_b;
    arrow_set_t pat;
    model = 16'hACE1;
    @(negedge CLOCK_50);
    old_a = lane_active_a;
    old_b = lane_active_b;
    @(posedge CLOCK_50);
    game_active <= 1'b1;
    // Tick after 20 active cycles, lanes two cycles later
    for (int c = 0; c <= 122; c++) begin
        @(negedge CLOCK_50);
        pat = '0;
        if (c >= 22 && (c - 22) % 20 == 0) begin
            pat   = expected_arrows(model[3:0]);
            model = lfsr_next(model);
        end
        check_set("lane_active_a rise", lane_active_a & ~old_a, pat & ~old_a);
        check_set("lane_active_b rise", lane_active_b & ~old_b, pat & ~old_b);
        old_a = lane_active_a;
        old_b = lane_active_b;
    end
    @(posedge CLOCK_50);
    game_active <= 1'b0;
    repeat (300) begin
        @(negedge CLOCK_50);
        check_set("lane_active_a rise", lane_active_a & ~old_a, 4'b0000);
        check_set("lane_active_b rise", lane_active_b & ~old_b, 4'b0000);
        old_a = lane_active_a;
        old_b = lane_active_b;
    end
    check_set("lane_active_a", lane_active_a, 4'b0000);  // All fell off
    check_set("lane_active_b", lane_active_b, 4'b0000);
endtask

task automatic test_hit_in_window();
    logic [1:0] lane;
    spawn_arrow(lane);
    wait_for_row(90);
    hit_lane(1'b0, lane, 1'b1);
    release_keys();
    hit_lane(1'b1, lane, 1'b1);           // B's copy still inside the window
    release_keys();
endtask

task automatic test_early_and_held();
    logic [1:0] lane;
    spawn_arrow(lane);
    wait_for_row(30);
    hit_lane(1'b0, lane, 1'b0);
    // Held down until the arrow is well past the window
    repeat (150) begin
        @(negedge CLOCK_50);
        check_bit("hit_a", hit_a, 1'b0);
    end
    check_bit("lane_active_a", lane_active_a[lane], 1'b1);
    release_keys();
endtask

task automatic test_miss();
    logic [1:0] lane;
    int         waited;
    spawn_arrow(lane);
    repeat (239) @(posedge CLOCK_50);     // Row has just reached 120
    @(negedge CLOCK_50);
    check_bit("lane_active_a", lane_active_a[lane], 1'b1);
    waited = 0;
    while (lane_active_a[lane]) begin
        @(negedge CLOCK_50);
        waited++;
        if (waited > 2) begin
            fail_run("An arrow stayed active past the bottom of the screen");
        end
    end
    check_scores();
endtask

task automatic test_saturation();
    logic [1:0] lane;
    repeat (100) begin
        spawn_arrow(lane);
        wait_for_row(90);
        hit_lane(1'b0, lane, 1'b1);
        release_keys();
    end
endtask

`endif

//--- verif/tb_rhythm_game.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rhythm_game;

    import rhythm_pkg::*;

    // Roughly 24000 cycles of tests with most of them in the 100-hit run
    localparam int CYCLE_LIMIT = 40000;
    localparam int SCORE_LIMIT = 99;

    logic       CLOCK_50 = 1'b0;
    logic       reset;
    logic       game_active;
    arrow_set_t player_a_keys;
    arrow_set_t player_b_keys;
    arrow_set_t lane_active_a;
    arrow_set_t lane_active_b;
    logic       hit_a;
    logic       hit_b;
    seg7_t      hex0;
    seg7_t      hex1;
    seg7_t      hex2;
    seg7_t      hex3;

    int          cycle = 0;
    int          score_a = 0;             // Expected scores
    int          score_b = 0;
    int unsigned lcg_state = 32'd19860;

    rhythm_game_top #(
        .SPAWN_INTERVAL(20),
        .MOVE_INTERVAL (2)
    ) i_dut (
        .CLOCK_50     (CLOCK_50),
        .reset        (reset),
        .game_active  (game_active),
        .player_a_keys(player_a_keys),
        .player_b_keys(player_b_keys),
        .lane_active_a(lane_active_a),
        .lane_active_b(lane_active_b),
        .hit_a        (hit_a),
        .hit_b        (hit_b),
        .hex0         (hex0),
        .hex1         (hex1),
        .hex2         (hex2),
        .hex3         (hex3)
    );

    always #50 CLOCK_50 = ~CLOCK_50;      // 100 ns period

    always @(posedge CLOCK_50) begin
        cycle <= cycle + 1;
        if (cycle == CYCLE_LIMIT) begin
            fail_run("The tests did not finish within the cycle limit");
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "%s", reason);
    endtask

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    `include "tb_tasks.svh"

    initial begin
        reset         = 1'b0;
        game_active   = 1'b0;
        player_a_keys = '0;
        player_b_keys = '0;
        apply_reset();
        test_reset_state();
        test_pattern_sequence();
        apply_reset();                    // Empty lanes and a fresh LFSR for play
        test_hit_in_window();
        test_early_and_held();
        test_miss();
        test_saturation();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
